// ==== fpu_defs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// word layout
`define FP_WIDTH 32
`define FP_BIAS 127

// exponent of 2**23, a 24-bit integer is exact here
`define FLT_EXPO 8'h96

// iterations of the sequential blocks
`define MUL_STEPS 24
`define DIV_STEPS 25

`endif

// ==== fpuPkg.sv ====
package fpuPkg;

`include "fpu_defs.svh"

  typedef enum logic [2:0] {
    opAdd   = 3'd0,
    opFlt   = 3'd1,  // integer to float
    opFloor = 3'd2,  // float to integer
    opMul   = 3'd3,
    opDiv   = 3'd4
  } fpOpT;

  typedef struct packed {
    logic        sign;
    logic [7:0]  expo;  // biased, zero means zero
    logic [22:0] frac;  // hidden one not stored
  } fpFieldsT;

  // one bus word, seen as a float or as a signed integer
  typedef union packed {
    fpFieldsT                 fld;
    logic [`FP_WIDTH-1:0]     intVal;
  } fpWordT;

endpackage

// ==== fpAdder.sv ====
`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpAdder import fpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   en,
  input  logic   run,
  input  logic   u,      // FLT
  input  logic   v,      // FLOOR
  input  fpWordT x,
  input  fpWordT y,
  output logic   stall,
  output fpWordT z
);

  logic [1:0] state;

  logic xs, ys, xn, yn;  // signs, zero flags
  logic [7:0] xe, ye;
  logic [24:0] xm, ym;
  logic [24:0] x0, y0;

  logic [8:0] dx, dy, e0, e1;
  logic [7:0] sx, sy;  // alignment shifts
  logic [24:0] x3, y3;

  logic [26:0] sum;
  logic [26:0] s;
  logic [4:0] sc;  // normalization shift
  logic [24:0] t2, t3;

  // arithmetic right shift with sign fill that saturates at 32
  function automatic logic [24:0] alignMant(
    input logic [24:0] m,
    input logic        sgn,
    input logic [7:0]  sh
  );
    logic signed [25:0] ext;
    ext = {sgn, m};
    if (sh[7:5] != 3'd0) begin
      return {25{sgn}};
    end
    ext = ext >>> sh[4:0];
    return ext[24:0];
  endfunction

  // unpack
  assign xs = x.fld.sign;
  assign xe = u ? `FLT_EXPO : x.fld.expo;
  assign xm = u ? {x.intVal[23:0], 1'b0} : {1'b1, x.fld.frac, 1'b0};
  assign xn = u ? (x.intVal == '0) : (x.fld.expo == 8'd0);
  assign ys = y.fld.sign;
  assign ye = y.fld.expo;
  assign ym = {~u & ~v, y.fld.frac, 1'b0};  // no hidden one for FLT/FLOOR anchor
  assign yn = (y.fld.expo == 8'd0);

  assign dx = {1'b0, xe} - {1'b0, ye};
  assign dy = {1'b0, ye} - {1'b0, xe};
  assign e0 = dx[8] ? {1'b0, ye} : {1'b0, xe};  // larger exponent
  assign sx = dy[8] ? 8'd0 : dy[7:0];
  assign sy = dx[8] ? 8'd0 : dx[7:0];

  // negate by sign unless the input is already a signed integer
  assign x0 = (xs & ~u) ? -xm : xm;
  assign y0 = (ys & ~u) ? -ym : ym;

  // stage 1 aligns
  always_ff @(posedge clk) begin
    if (en) begin
      x3 <= alignMant(x0, xs, sx);
      y3 <= alignMant(y0, ys, sy);
    end
  end

  // stage 2 adds
  always_ff @(posedge clk) begin
    if (en) begin
      sum <= {xs, xs, x3} + {ys, ys, y3};
    end
  end

  assign s = sum[26] ? -sum : sum;  // magnitude

  // leading one found by pairs of bits
  always_comb begin
    sc = 5'd24;  // nothing found above bit 2
    for (int k = 0; k < 12; k++) begin
      if (s[2*k+3] | s[2*k+2]) begin
        sc = 5'(22 - 2*k) + (s[2*k+3] ? 5'd0 : 5'd1);
      end
    end
  end

  assign e1 = e0 - {4'd0, sc} + 9'd1;
  assign t2 = s[25:1] << sc;

  // stage 3 normalizes
  always_ff @(posedge clk) begin
    if (en) begin
      t3 <= t2;
    end
  end

  assign stall = run & (state != 2'd3);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= 2'd0;
    end else if (en) begin
      state <= run ? state + 2'd1 : 2'd0;
    end
  end

  always_comb begin
    if (v) begin
      z.intVal = {{7{sum[26]}}, sum[25:1]};  // FLOOR
    end else if (xn) begin
      z = (u | yn) ? fpWordT'('0) : y;
    end else if (yn) begin
      z = x;
    end else if ((t3 == '0) || e1[8]) begin
      z.intVal = '0;  // cancellation or underflow
    end else begin
      z.fld.sign = sum[26];
      z.fld.expo = e1[7:0];
      z.fld.frac = t3[23:1];
    end
  end

  // a new operation starts from a cleared step count
  assert property (@(posedge clk) disable iff (!rstN) $rose(run) |-> (state == 2'd0));

endmodule

// ==== fpMultiplier.sv ====
`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpMultiplier import fpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   en,
  input  logic   run,
  input  fpWordT x,
  input  fpWordT y,
  output logic   stall,
  output fpWordT z
);

  localparam int LastStep = `MUL_STEPS + 1;
  localparam int CntW = $clog2(LastStep + 1);

  logic [CntW-1:0] cnt;
  logic [47:0] prod;  // high half accumulates while low half shifts out the multiplier
  logic [23:0] mcand;
  logic [24:0] partial;
  logic signed [9:0] e;
  logic zeroRes;

  assign mcand = {1'b1, x.fld.frac};
  assign partial = {1'b0, prod[47:24]} + (prod[0] ? {1'b0, mcand} : 25'd0);

  assign stall = run & (cnt != CntW'(LastStep));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cnt <= '0;
    end else if (en) begin
      if (!run) begin
        cnt <= '0;
      end else if (cnt != CntW'(LastStep)) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en && run) begin
      if (cnt == '0) begin
        prod <= {24'd0, 1'b1, y.fld.frac};  // load multiplier
      end else if (cnt <= CntW'(`MUL_STEPS)) begin
        prod <= {partial, prod[23:1]};  // one shift-and-add step
      end
    end
  end

  // product of two values in [1,2) lies in [1,4)
  assign e = 10'(x.fld.expo) + 10'(y.fld.expo) - 10'(`FP_BIAS) + 10'(prod[47]);

  assign zeroRes = (x.fld.expo == 8'd0) || (y.fld.expo == 8'd0) || (e <= 0);

  always_comb begin
    if (zeroRes) begin
      z.intVal = '0;
    end else begin
      z.fld.sign = x.fld.sign ^ y.fld.sign;
      z.fld.expo = e[7:0];
      z.fld.frac = prod[47] ? prod[46:24] : prod[45:23];  // truncated
    end
  end

  // the multiplicand is read on every step
  assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(x.intVal));

endmodule

// ==== fpDivider.sv ====
`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpDivider import fpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   en,
  input  logic   run,
  input  fpWordT x,
  input  fpWordT y,
  output logic   stall,
  output fpWordT z
);

  localparam int LastStep = `DIV_STEPS + 1;
  localparam int CntW = $clog2(LastStep + 1);

  logic [CntW-1:0] cnt;
  logic [24:0] rem;   // partial remainder stays below twice the divisor
  logic [24:0] quo;   // msb has weight 1.0
  logic [23:0] dvsr;
  logic [25:0] diff;
  logic qBit;
  logic signed [9:0] e;
  logic zeroRes;

  assign dvsr = {1'b1, y.fld.frac};
  assign diff = {1'b0, rem} - {2'b00, dvsr};
  assign qBit = ~diff[25];  // remainder covers the divisor

  assign stall = run & (cnt != CntW'(LastStep));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cnt <= '0;
    end else if (en) begin
      if (!run) begin
        cnt <= '0;
      end else if (cnt != CntW'(LastStep)) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en && run) begin
      if (cnt == '0) begin
        rem <= {1'b0, 1'b1, x.fld.frac};
        quo <= '0;
      end else if (cnt <= CntW'(`DIV_STEPS)) begin
        rem <= (qBit ? diff[24:0] : rem) << 1;  // restore by keeping rem
        quo <= {quo[23:0], qBit};
      end
    end
  end

  // quotient in (0.5,2) needs one left shift at most
  assign e = 10'(x.fld.expo) - 10'(y.fld.expo) + 10'(`FP_BIAS) - (quo[24] ? 10'd0 : 10'd1);

  assign zeroRes = (x.fld.expo == 8'd0) || (e <= 0);

  always_comb begin
    if (zeroRes) begin
      z.intVal = '0;
    end else begin
      z.fld.sign = x.fld.sign ^ y.fld.sign;
      z.fld.expo = e[7:0];
      z.fld.frac = quo[24] ? quo[23:1] : quo[22:0];
    end
  end

  // the CPU never divides by zero
  assert property (@(posedge clk) disable iff (!rstN) run |-> (y.fld.expo != 8'd0));

endmodule

// ==== fpUnit.sv ====
`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpUnit import fpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   en,
  input  logic   run,
  input  fpOpT   op,
  input  fpWordT x,
  input  fpWordT y,
  output logic   stall,
  output fpWordT z
);

  // 2**23 as a float, fixes the binary point for FLT and FLOOR
  localparam logic [`FP_WIDTH-1:0] FltAnchor = {1'b0, `FLT_EXPO, 23'd0};

  logic isAdd, u, v;
  logic runAdd, runMul, runDiv;
  logic stallAdd, stallMul, stallDiv;
  fpWordT yAdd, zAdd, zMul, zDiv;

  assign u = (op == opFlt);
  assign v = (op == opFloor);
  assign isAdd = (op == opAdd) | u | v;

  assign runAdd = run & isAdd;
  assign runMul = run & (op == opMul);
  assign runDiv = run & (op == opDiv);

  assign yAdd.intVal = (u | v) ? FltAnchor : y.intVal;

  fpAdder adder (
    .clk(clk), .rstN(rstN), .en(en), .run(runAdd), .u(u), .v(v),
    .x(x), .y(yAdd), .stall(stallAdd), .z(zAdd)
  );

  fpMultiplier mul (
    .clk(clk), .rstN(rstN), .en(en), .run(runMul),
    .x(x), .y(y), .stall(stallMul), .z(zMul)
  );

  fpDivider div (
    .clk(clk), .rstN(rstN), .en(en), .run(runDiv),
    .x(x), .y(y), .stall(stallDiv), .z(zDiv)
  );

  assign stall = stallAdd | stallMul | stallDiv;

  always_comb begin
    case (op)
      opMul:   z = zMul;
      opDiv:   z = zDiv;
      default: z = zAdd;  // add, FLT, FLOOR
    endcase
  end

  // a block mid-operation must keep its op select
  assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(op));

endmodule

// ==== fpRefModel.svh ====
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// add, FLT and FLOOR, all through one aligned two's complement sum
function automatic logic [31:0] refAdd(
  input logic [31:0] a,
  input logic [31:0] b,
  input bit          u,
  input bit          v
);
  int ea, eb, big, sa, sb, sc, e;
  longint ma, mb, va, vb, sum, mag;
  logic [24:0] t;
  logic [31:0] r;
  ea = u ? `FLT_EXPO : a[30:23];
  eb = b[30:23];
  ma = u ? {a[23:0], 1'b0} : {1'b1, a[22:0], 1'b0};  // one guard bit below
  mb = (u || v) ? {b[22:0], 1'b0} : {1'b1, b[22:0], 1'b0};
  if (u) begin
    va = ma - (longint'(a[31]) << 25);  // integer already signed
  end else begin
    va = a[31] ? -ma : ma;
  end
  vb = b[31] ? -mb : mb;
  big = (ea > eb) ? ea : eb;
  sa = (eb > ea) ? eb - ea : 0;
  sb = (ea > eb) ? ea - eb : 0;
  va = (sa >= 32) ? (a[31] ? -1 : 0) : (va >>> sa);  // truncating shift
  vb = (sb >= 32) ? (b[31] ? -1 : 0) : (vb >>> sb);
  sum = va + vb;
  mag = (sum < 0) ? -sum : sum;
  sc = 24;
  for (int p = 2; p <= 25; p++) begin
    if (mag[p]) sc = 25 - p;
  end
  e = big - sc + 1;
  t = mag[25:1];
  t = t << sc;
  if (v) begin
    r = 32'(sum >>> 1);  // floor toward minus infinity
  end else if (u ? (a == 32'd0) : (ea == 0)) begin
    r = (u || eb == 0) ? 32'd0 : b;
  end else if (eb == 0) begin
    r = a;
  end else if (t == 25'd0 || e < 0 || e > 255) begin
    r = 32'd0;
  end else begin
    r = {sum < 0, 8'(e), t[23:1]};
  end
  return r;
endfunction

function automatic logic [31:0] refMul(input logic [31:0] a, input logic [31:0] b);
  longint p;
  int e;
  p = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
  e = a[30:23] + b[30:23] - `FP_BIAS + p[47];
  if (a[30:23] == 0 || b[30:23] == 0 || e <= 0) return 32'd0;
  return {a[31] ^ b[31], 8'(e), p[47] ? p[46:24] : p[45:23]};
endfunction

function automatic logic [31:0] refDiv(input logic [31:0] a, input logic [31:0] b);
  longint q;
  int e;
  q = (longint'({1'b1, a[22:0]}) << 24) / longint'({1'b1, b[22:0]});
  e = a[30:23] - b[30:23] + `FP_BIAS - (q[24] ? 0 : 1);
  if (a[30:23] == 0 || e <= 0) return 32'd0;
  return {a[31] ^ b[31], 8'(e), q[24] ? q[23:1] : q[22:0]};
endfunction

`endif

// ==== fpUnitTb.sv ====
`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpUnitTb import fpuPkg::*; ();

`include "fpRefModel.svh"

  localparam int NumAdd = 60;
  localparam int NumFlt = 20;
  localparam int NumFloor = 20;
  localparam int NumMul = 40;
  localparam int NumDiv = 40;
  localparam int MaxGap = 4;  // en low cycles per stretched op
  localparam int AddOps = NumAdd + 3 + NumFlt + NumFloor;
  localparam int MulOps = NumMul + 2;
  localparam int OpSlack = MaxGap + 4;
  localparam int CycleLimit = (AddOps * (3 + OpSlack) + MulOps * (`MUL_STEPS + 1 + OpSlack)
                             + NumDiv * (`DIV_STEPS + 1 + OpSlack)) * 3 / 2 + 3;
  localparam logic [31:0] Anchor = {1'b0, `FLT_EXPO, 23'd0};

  logic clk = 1'b0;
  logic rstN, en, run, stall;
  fpOpT op;
  fpWordT x, y, z;

  int seed = 67920;
  int valErrors = 0;
  int latErrors = 0;
  int cycleCount = 0;
  int opCount = 0;
  bit gapOn;
  int gapLeft;
  logic [31:0] a, b, r;

  fpUnit UUT (
    .clk(clk), .rstN(rstN), .en(en), .run(run), .op(op),
    .x(x), .y(y), .stall(stall), .z(z)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the DUT did not finish its operations within %0d cycles", CycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  // en drops now and then on stretched ops, bounded per op
  function automatic logic pickEn();
    if (gapOn && gapLeft > 0 && ($random(seed) & 3) == 0) begin
      gapLeft--;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic logic [31:0] randFloat(input int loE, input int hiE);
    logic [31:0] rv;
    int e;
    rv = $random(seed);
    e = loE + ({$random(seed)} % (hiE - loE + 1));
    return {rv[31], 8'(e), rv[22:0]};
  endfunction

  task automatic doOp(input fpOpT o, input logic [31:0] xa, input logic [31:0] yb,
                      input logic [31:0] expected);
    int stallCycles;
    int expStall;
    expStall = (o == opMul) ? `MUL_STEPS + 1 : (o == opDiv) ? `DIV_STEPS + 1 : 3;
    stallCycles = 0;
    gapOn = (opCount % 3 == 0);
    gapLeft = MaxGap;
    opCount++;
    @(negedge clk);
    op = o;
    x = xa;
    y = yb;
    run = 1'b1;
    en = pickEn();
    #1;
    while (!(en && !stall)) begin
      if (en) stallCycles++;
      @(negedge clk);
      en = pickEn();
      #1;
    end
    assert (z.intVal === expected) else begin
      valErrors++;
      $display("CHECK FAILED: z = %h, expected %h (op %s, x %h, y %h)",
               z.intVal, expected, o.name(), xa, yb);
    end
    assert (stallCycles == expStall) else begin
      latErrors++;
      $display("CHECK FAILED: stall high for %h enabled cycles, expected %h (op %s)",
               stallCycles, expStall, o.name());
    end
    @(negedge clk);
    run = 1'b0;  // one idle cycle clears the step counters
    en = 1'b1;
  endtask

  initial begin
    rstN = 1'b0;
    en = 1'b1;
    run = 1'b0;
    op = opAdd;
    x = '0;
    y = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    for (int i = 0; i < NumAdd; i++) begin
      a = randFloat(96, 160);
      b = randFloat(96, 160);
      doOp(opAdd, a, b, refAdd(a, b, 1'b0, 1'b0));
    end
    a = randFloat(100, 150);
    doOp(opAdd, a, a ^ 32'h8000_0000, 32'd0);  // exact cancellation
    b = randFloat(100, 150);
    doOp(opAdd, 32'd0, b, b);
    doOp(opAdd, a, 32'd0, a);

    for (int i = 0; i < NumFlt; i++) begin
      r = $random(seed);
      a = {{8{r[23]}}, r[23:0]};
      doOp(opFlt, a, $random(seed), refAdd(a, Anchor, 1'b1, 1'b0));
    end
    for (int i = 0; i < NumFloor; i++) begin
      a = randFloat(100, 150);
      doOp(opFloor, a, $random(seed), refAdd(a, Anchor, 1'b0, 1'b1));
    end

    for (int i = 0; i < NumMul; i++) begin
      a = randFloat(70, 180);
      b = randFloat(70, 180);
      doOp(opMul, a, b, refMul(a, b));
    end
    doOp(opMul, 32'd0, randFloat(70, 180), 32'd0);
    doOp(opMul, randFloat(10, 40), randFloat(10, 40), 32'd0);  // exponent underflow

    for (int i = 0; i < NumDiv; i++) begin
      a = randFloat(64, 191);
      b = randFloat(64, 191);
      doOp(opDiv, a, b, refDiv(a, b));
    end

    $display("Errors: %0d on z, %0d on stall latency", valErrors, latErrors);
    if (valErrors + latErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
fpuPkg.sv
fpAdder.sv
fpMultiplier.sv
fpDivider.sv
fpUnit.sv
fpUnitTb.sv

// ==== Bender.yml ====
package:
  name: fp_unit

sources:
  - include_dirs:
      - .
    files:
      - fpuPkg.sv
      - fpAdder.sv
      - fpMultiplier.sv
      - fpDivider.sv
      - fpUnit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - fpUnitTb.sv
